// ==== files.f ====
hw/soc_pkg.sv
hw/axi4lite.sv
hw/axil_requester.sv
hw/axil_arbiter.sv
hw/axil_decoder.sv
hw/axil_sram.sv
hw/axil_gpio.sv
hw/soc_fabric.sv
sim/soc_fabric_tb.sv

// ==== hw/axi4lite.sv ====
`timescale 1ns/10ps

interface axi4lite;

    soc_pkg::addr_t awaddr;
    logic [2:0] awprot;
    logic awvalid;
    logic awready;

    soc_pkg::data_t wdata;
    soc_pkg::strb_t wstrb;
    logic wvalid;
    logic wready;

    soc_pkg::resp_t bresp;
    logic bvalid;
    logic bready;

    soc_pkg::addr_t araddr;
    logic [2:0] arprot;
    logic arvalid;
    logic arready;

    soc_pkg::data_t rdata;
    soc_pkg::resp_t rresp;
    logic rvalid;
    logic rready;

    modport master (
        output awaddr, awprot, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arprot, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport slave (
        input awaddr, awprot, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arprot, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

// ==== hw/axil_arbiter.sv ====
`timescale 1ns/10ps

module axil_arbiter (
    input logic clk,
    input logic rst,
    axi4lite.slave m0,
    axi4lite.slave m1,
    axi4lite.master s
);

logic lock;
logic grant;
logic last;
logic req0;
logic req1;
logic pick;
logic sel0;
logic sel1;
logic finish;

assign req0 = m0.awvalid || m0.arvalid;
assign req1 = m1.awvalid || m1.arvalid;

// On a tie the master not served last wins
assign pick = (req0 && req1) ? !last : req1;

assign sel0 = lock && !grant;
assign sel1 = lock && grant;
assign finish = (s.bvalid && s.bready) || (s.rvalid && s.rready);

always_ff @(posedge clk) begin
    if (rst) begin
        lock <= 1'b0;
        grant <= 1'b0;
        last <= 1'b0;
    end else if (!lock) begin
        if (req0 || req1) begin
            lock <= 1'b1;
            grant <= pick;
        end
    end else if (finish) begin
        lock <= 1'b0;
        last <= grant;
    end
end

// Requests from the granted master
assign s.awaddr = grant ? m1.awaddr : m0.awaddr;
assign s.awprot = grant ? m1.awprot : m0.awprot;
assign s.awvalid = lock && (grant ? m1.awvalid : m0.awvalid);
assign s.wdata = grant ? m1.wdata : m0.wdata;
assign s.wstrb = grant ? m1.wstrb : m0.wstrb;
assign s.wvalid = lock && (grant ? m1.wvalid : m0.wvalid);
assign s.bready = lock && (grant ? m1.bready : m0.bready);
assign s.araddr = grant ? m1.araddr : m0.araddr;
assign s.arprot = grant ? m1.arprot : m0.arprot;
assign s.arvalid = lock && (grant ? m1.arvalid : m0.arvalid);
assign s.rready = lock && (grant ? m1.rready : m0.rready);

// Fetch side
assign m0.awready = sel0 && s.awready;
assign m0.wready = sel0 && s.wready;
assign m0.bresp = s.bresp;
assign m0.bvalid = sel0 && s.bvalid;
assign m0.arready = sel0 && s.arready;
assign m0.rdata = s.rdata;
assign m0.rresp = s.rresp;
assign m0.rvalid = sel0 && s.rvalid;

// Data side
assign m1.awready = sel1 && s.awready;
assign m1.wready = sel1 && s.wready;
assign m1.bresp = s.bresp;
assign m1.bvalid = sel1 && s.bvalid;
assign m1.arready = sel1 && s.arready;
assign m1.rdata = s.rdata;
assign m1.rresp = s.rresp;
assign m1.rvalid = sel1 && s.rvalid;

endmodule

// ==== hw/axil_decoder.sv ====
`timescale 1ns/10ps

module axil_decoder (
    input logic clk,
    input logic rst,
    axi4lite.slave up,
    axi4lite.master sram,
    axi4lite.master gpio
);

logic [3:0] w_region;
logic [3:0] r_region;
logic w_sram;
logic w_gpio;
logic w_err;
logic r_sram;
logic r_gpio;
logic r_err;
logic err_bvalid;
logic err_rvalid;
logic err_w_take;
logic err_r_take;

assign w_region = up.awaddr[soc_pkg::alen-1 -: 4];
assign r_region = up.araddr[soc_pkg::alen-1 -: 4];
assign w_sram = w_region == soc_pkg::region_sram;
assign w_gpio = w_region == soc_pkg::region_gpio;
assign w_err = !w_sram && !w_gpio;
assign r_sram = r_region == soc_pkg::region_sram;
assign r_gpio = r_region == soc_pkg::region_gpio;
assign r_err = !r_sram && !r_gpio;

// Unmapped requests are absorbed here
assign err_w_take = up.awvalid && up.wvalid && w_err && !err_bvalid;
assign err_r_take = up.arvalid && r_err && !err_rvalid;

always_ff @(posedge clk) begin
    if (rst) begin
        err_bvalid <= 1'b0;
        err_rvalid <= 1'b0;
    end else begin
        if (err_bvalid && up.bready) begin
            err_bvalid <= 1'b0;
        end
        if (err_w_take) begin
            err_bvalid <= 1'b1;
        end
        if (err_rvalid && up.rready) begin
            err_rvalid <= 1'b0;
        end
        if (err_r_take) begin
            err_rvalid <= 1'b1;
        end
    end
end

assign sram.awaddr = up.awaddr;
assign sram.awprot = up.awprot;
assign sram.awvalid = up.awvalid && w_sram;
assign sram.wdata = up.wdata;
assign sram.wstrb = up.wstrb;
assign sram.wvalid = up.wvalid && w_sram;
assign sram.bready = up.bready;
assign sram.araddr = up.araddr;
assign sram.arprot = up.arprot;
assign sram.arvalid = up.arvalid && r_sram;
assign sram.rready = up.rready;

assign gpio.awaddr = up.awaddr;
assign gpio.awprot = up.awprot;
assign gpio.awvalid = up.awvalid && w_gpio;
assign gpio.wdata = up.wdata;
assign gpio.wstrb = up.wstrb;
assign gpio.wvalid = up.wvalid && w_gpio;
assign gpio.bready = up.bready;
assign gpio.araddr = up.araddr;
assign gpio.arprot = up.arprot;
assign gpio.arvalid = up.arvalid && r_gpio;
assign gpio.rready = up.rready;

assign up.awready = (w_sram && sram.awready) || (w_gpio && gpio.awready) || err_w_take;
assign up.wready = (w_sram && sram.wready) || (w_gpio && gpio.wready) || err_w_take;
assign up.arready = (r_sram && sram.arready) || (r_gpio && gpio.arready) || err_r_take;

// Only one response can be pending at a time
assign up.bvalid = sram.bvalid || gpio.bvalid || err_bvalid;
assign up.bresp = err_bvalid ? soc_pkg::resp_decerr :
                  sram.bvalid ? sram.bresp : gpio.bresp;
assign up.rvalid = sram.rvalid || gpio.rvalid || err_rvalid;
assign up.rdata = sram.rvalid ? sram.rdata :
                  gpio.rvalid ? gpio.rdata : '0;
assign up.rresp = err_rvalid ? soc_pkg::resp_decerr :
                  sram.rvalid ? sram.rresp : gpio.rresp;

endmodule

// ==== hw/axil_gpio.sv ====
`timescale 1ns/10ps

module axil_gpio #(
    parameter int num_outputs = 4,
    parameter soc_pkg::addr_t addr_mask = 32'h0fff_ffff
) (
    input  logic clk,
    input  logic rst,
    axi4lite.slave bus,
    output logic [num_outputs-1:0] outputs
);

localparam int lsb = $clog2(soc_pkg::strb_w);

logic [num_outputs-1:0] out_q;
soc_pkg::data_t merged;
soc_pkg::data_t rdata_q;
soc_pkg::addr_t woff;
soc_pkg::addr_t roff;
logic w_hit;
logic r_hit;
logic w_take;
logic r_take;
logic bvalid_q;
logic rvalid_q;

// Register lives in word 0, everything else reads zero
assign woff = bus.awaddr & addr_mask;
assign roff = bus.araddr & addr_mask;
assign w_hit = woff[soc_pkg::alen-1:lsb] == '0;
assign r_hit = roff[soc_pkg::alen-1:lsb] == '0;

assign w_take = bus.awvalid && bus.wvalid && !bvalid_q;
assign r_take = bus.arvalid && !rvalid_q;

always_comb begin
    merged = soc_pkg::data_t'(out_q);
    for (int i = 0; i < soc_pkg::strb_w; i++) begin
        if (bus.wstrb[i]) begin
            merged[8*i +: 8] = bus.wdata[8*i +: 8];
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        out_q <= '0;
        bvalid_q <= 1'b0;
        rvalid_q <= 1'b0;
    end else begin
        if (w_take && w_hit) begin
            out_q <= merged[num_outputs-1:0];
        end
        if (bvalid_q && bus.bready) begin
            bvalid_q <= 1'b0;
        end
        if (w_take) begin
            bvalid_q <= 1'b1;
        end
        if (rvalid_q && bus.rready) begin
            rvalid_q <= 1'b0;
        end
        if (r_take) begin
            rvalid_q <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (r_take) begin
        rdata_q <= r_hit ? soc_pkg::data_t'(out_q) : '0;
    end
end

assign bus.awready = w_take;
assign bus.wready = w_take;
assign bus.arready = !rvalid_q;
assign bus.bvalid = bvalid_q;
assign bus.bresp = soc_pkg::resp_okay;
assign bus.rvalid = rvalid_q;
assign bus.rdata = rdata_q;
assign bus.rresp = soc_pkg::resp_okay;

assign outputs = out_q;

endmodule

// ==== hw/axil_requester.sv ====
`timescale 1ns/10ps

module axil_requester #(
    parameter bit write_en = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic we,
    input  soc_pkg::addr_t addr,
    input  soc_pkg::data_t wdata,
    input  soc_pkg::strb_t wstrb,
    output logic busy,
    output logic done,
    output soc_pkg::data_t rdata,
    output soc_pkg::resp_t resp,
    axi4lite.master bus
);

typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read
} state_t;

// Instruction accesses are flagged through prot[2]
localparam logic [2:0] prot = write_en ? 3'b000 : 3'b100;

state_t state;
logic aw_pending;
logic w_pending;
logic ar_pending;
soc_pkg::addr_t addr_q;
soc_pkg::data_t wdata_q;
soc_pkg::strb_t wstrb_q;

assign busy = state != st_idle;

assign bus.awaddr = addr_q;
assign bus.awprot = prot;
assign bus.awvalid = aw_pending;
assign bus.wdata = wdata_q;
assign bus.wstrb = wstrb_q;
assign bus.wvalid = w_pending;
assign bus.bready = 1'b1;
assign bus.araddr = addr_q;
assign bus.arprot = prot;
assign bus.arvalid = ar_pending;
assign bus.rready = 1'b1;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= st_idle;
        aw_pending <= 1'b0;
        w_pending <= 1'b0;
        ar_pending <= 1'b0;
        done <= 1'b0;
    end else begin
        done <= 1'b0;
        case (state)
            st_idle: begin
                if (req && write_en && we) begin
                    state <= st_write;
                    aw_pending <= 1'b1;
                    w_pending <= 1'b1;
                end else if (req) begin
                    state <= st_read;
                    ar_pending <= 1'b1;
                end
            end
            st_write: begin
                // Each valid drops after its own handshake
                if (bus.awvalid && bus.awready) begin
                    aw_pending <= 1'b0;
                end
                if (bus.wvalid && bus.wready) begin
                    w_pending <= 1'b0;
                end
                if (bus.bvalid && bus.bready) begin
                    state <= st_idle;
                    done <= 1'b1;
                end
            end
            st_read: begin
                if (bus.arvalid && bus.arready) begin
                    ar_pending <= 1'b0;
                end
                if (bus.rvalid && bus.rready) begin
                    state <= st_idle;
                    done <= 1'b1;
                end
            end
            default: state <= st_idle;
        endcase
    end
end

// Request payload and response capture
always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
        addr_q <= addr;
        wdata_q <= wdata;
        wstrb_q <= wstrb;
    end
    if (state == st_write && bus.bvalid && bus.bready) begin
        resp <= bus.bresp;
        rdata <= '0;
    end
    if (state == st_read && bus.rvalid && bus.rready) begin
        resp <= bus.rresp;
        rdata <= bus.rdata;
    end
end

endmodule

// ==== hw/axil_sram.sv ====
`timescale 1ns/10ps

module axil_sram #(
    parameter int size_kb = 8,
    parameter soc_pkg::addr_t addr_mask = 32'h0fff_ffff
) (
    input logic clk,
    input logic rst,
    axi4lite.slave bus
);

localparam int words = size_kb * 1024 / soc_pkg::strb_w;
localparam int idx_w = $clog2(words);
localparam int lsb = $clog2(soc_pkg::strb_w);

soc_pkg::data_t mem [0:words-1];
soc_pkg::data_t rdata_q;
soc_pkg::addr_t waddr_m;
soc_pkg::addr_t raddr_m;
logic [idx_w-1:0] widx;
logic [idx_w-1:0] ridx;
logic w_take;
logic r_take;
logic bvalid_q;
logic rvalid_q;

assign waddr_m = bus.awaddr & addr_mask;
assign raddr_m = bus.araddr & addr_mask;
assign widx = waddr_m[lsb +: idx_w];
assign ridx = raddr_m[lsb +: idx_w];

assign w_take = bus.awvalid && bus.wvalid && !bvalid_q;
assign r_take = bus.arvalid && !rvalid_q;

assign bus.awready = w_take;
assign bus.wready = w_take;
assign bus.arready = !rvalid_q;
assign bus.bvalid = bvalid_q;
assign bus.bresp = soc_pkg::resp_okay;
assign bus.rvalid = rvalid_q;
assign bus.rdata = rdata_q;
assign bus.rresp = soc_pkg::resp_okay;

always_ff @(posedge clk) begin
    if (rst) begin
        bvalid_q <= 1'b0;
        rvalid_q <= 1'b0;
    end else begin
        if (bvalid_q && bus.bready) begin
            bvalid_q <= 1'b0;
        end
        if (w_take) begin
            bvalid_q <= 1'b1;
        end
        if (rvalid_q && bus.rready) begin
            rvalid_q <= 1'b0;
        end
        if (r_take) begin
            rvalid_q <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (w_take) begin
        for (int i = 0; i < soc_pkg::strb_w; i++) begin
            if (bus.wstrb[i]) begin
                mem[widx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end
    if (r_take) begin
        rdata_q <= mem[ridx];
    end
end

endmodule

// ==== hw/soc_fabric.sv ====
`timescale 1ns/10ps

module soc_fabric #(
    parameter int sram_kb = 8,
    parameter int num_gpio_outputs = 4
) (
    input  logic clk,
    input  logic rst,

    // Instruction fetch port
    input  logic fetch_req,
    input  soc_pkg::addr_t fetch_addr,
    output logic fetch_busy,
    output logic fetch_done,
    output soc_pkg::data_t fetch_rdata,
    output soc_pkg::resp_t fetch_resp,

    // Load/store port
    input  logic data_req,
    input  logic data_we,
    input  soc_pkg::addr_t data_addr,
    input  soc_pkg::data_t data_wdata,
    input  soc_pkg::strb_t data_wstrb,
    output logic data_busy,
    output logic data_done,
    output soc_pkg::data_t data_rdata,
    output soc_pkg::resp_t data_resp,

    output logic [num_gpio_outputs-1:0] gpio_outputs
);

axi4lite fetch_bus();
axi4lite data_bus();
axi4lite shared_bus();
axi4lite sram_bus();
axi4lite gpio_bus();

// Fetch side is read only
axil_requester #(
    .write_en(1'b0)
) fetch_req0 (
    .clk,
    .rst,
    .req(fetch_req),
    .we(1'b1),
    .addr(fetch_addr),
    .wdata('0),
    .wstrb('0),
    .busy(fetch_busy),
    .done(fetch_done),
    .rdata(fetch_rdata),
    .resp(fetch_resp),
    .bus(fetch_bus)
);

axil_requester #(
    .write_en(1'b1)
) data_req0 (
    .clk,
    .rst,
    .req(data_req),
    .we(data_we),
    .addr(data_addr),
    .wdata(data_wdata),
    .wstrb(data_wstrb),
    .busy(data_busy),
    .done(data_done),
    .rdata(data_rdata),
    .resp(data_resp),
    .bus(data_bus)
);

axil_arbiter arbiter0 (
    .clk,
    .rst,
    .m0(fetch_bus),
    .m1(data_bus),
    .s(shared_bus)
);

axil_decoder decoder0 (
    .clk,
    .rst,
    .up(shared_bus),
    .sram(sram_bus),
    .gpio(gpio_bus)
);

// Base 0x1000_0000
axil_sram #(
    .size_kb(sram_kb),
    .addr_mask(32'h0fff_ffff)
) sram0 (
    .clk,
    .rst,
    .bus(sram_bus)
);

// Base 0x2000_0000
axil_gpio #(
    .num_outputs(num_gpio_outputs),
    .addr_mask(32'h0fff_ffff)
) gpio0 (
    .clk,
    .rst,
    .bus(gpio_bus),
    .outputs(gpio_outputs)
);

endmodule

// ==== hw/soc_pkg.sv ====
package soc_pkg;

    // Bus geometry
    localparam int alen = 32;
    localparam int xlen = 64;
    localparam int strb_w = xlen / 8;

    typedef logic [alen-1:0] addr_t;
    typedef logic [xlen-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'd0;
    localparam resp_t resp_decerr = 2'd3;

    // Device select on addr[31:28]
    localparam logic [3:0] region_sram = 4'd1;
    localparam logic [3:0] region_gpio = 4'd2;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps --top-module soc_fabric_tb \
    -f files.f -o soc_fabric_sim
./obj_dir/soc_fabric_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

// ==== sim/soc_fabric_tb.sv ====
`timescale 1ns/10ps

module soc_fabric_tb;

localparam soc_pkg::addr_t gpio_base = 32'h2000_0000;
localparam soc_pkg::addr_t pool_base = 32'h1000_0100;
// About 90 transactions at under 8 cycles each, so 3000 leaves a wide margin
localparam int max_cycles = 3000;

logic clk = 1'b0;
logic rst;
logic fetch_req;
soc_pkg::addr_t fetch_addr;
logic fetch_busy;
logic fetch_done;
soc_pkg::data_t fetch_rdata;
soc_pkg::resp_t fetch_resp;
logic data_req;
logic data_we;
soc_pkg::addr_t data_addr;
soc_pkg::data_t data_wdata;
soc_pkg::strb_t data_wstrb;
logic data_busy;
logic data_done;
soc_pkg::data_t data_rdata;
soc_pkg::resp_t data_resp;
logic [3:0] gpio_outputs;

// Reference models of the two devices
logic [7:0] sram_bytes [0:8191];
logic [3:0] gpio_model;

int errors = 0;
int cycles = 0;
integer seed = 67142;

soc_fabric #(
    .sram_kb(8),
    .num_gpio_outputs(4)
) dut0 (
    .clk,
    .rst,
    .fetch_req,
    .fetch_addr,
    .fetch_busy,
    .fetch_done,
    .fetch_rdata,
    .fetch_resp,
    .data_req,
    .data_we,
    .data_addr,
    .data_wdata,
    .data_wstrb,
    .data_busy,
    .data_done,
    .data_rdata,
    .data_resp,
    .gpio_outputs
);

always #50 clk = ~clk;

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
        $display("Timeout after %0d cycles, a transaction never completed", cycles);
        $display("*** FAILED ***");
        $fatal(1, "Simulation timeout");
    end
end

task automatic check(input string name, input soc_pkg::data_t got, input soc_pkg::data_t exp);
    if (got !== exp) begin
        errors++;
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

function automatic soc_pkg::data_t fill_word(input soc_pkg::addr_t addr);
    return {addr ^ 32'ha5a5_0f0f, ~addr};
endfunction

function automatic soc_pkg::data_t model_read(input soc_pkg::addr_t addr);
    soc_pkg::data_t word;
    for (int i = 0; i < 8; i++) begin
        word[8*i +: 8] = sram_bytes[{addr[12:3], i[2:0]}];
    end
    return word;
endfunction

task automatic model_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                           input soc_pkg::strb_t strb);
    for (int i = 0; i < 8; i++) begin
        if (strb[i]) begin
            sram_bytes[{addr[12:3], i[2:0]}] = data[8*i +: 8];
        end
    end
endtask

// Only word 0 holds the register, and only byte lane 0 reaches 4 outputs
task automatic gpio_model_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                                input soc_pkg::strb_t strb);
    if (addr[27:3] == '0 && strb[0]) begin
        gpio_model = data[3:0];
    end
endtask

task automatic do_data(input logic we, input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                       input soc_pkg::strb_t wstrb, output soc_pkg::data_t rdata,
                       output soc_pkg::resp_t resp);
    @(negedge clk);
    while (data_busy) begin
        @(negedge clk);
    end
    data_req = 1'b1;
    data_we = we;
    data_addr = addr;
    data_wdata = wdata;
    data_wstrb = wstrb;
    @(negedge clk);
    data_req = 1'b0;
    check("data_busy", 64'(data_busy), 64'd1);
    while (!data_done) begin
        @(negedge clk);
    end
    rdata = data_rdata;
    resp = data_resp;
    check("data_busy", 64'(data_busy), 64'd0);
endtask

task automatic do_fetch(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata,
                        output soc_pkg::resp_t resp);
    @(negedge clk);
    while (fetch_busy) begin
        @(negedge clk);
    end
    fetch_req = 1'b1;
    fetch_addr = addr;
    @(negedge clk);
    fetch_req = 1'b0;
    check("fetch_busy", 64'(fetch_busy), 64'd1);
    while (!fetch_done) begin
        @(negedge clk);
    end
    rdata = fetch_rdata;
    resp = fetch_resp;
    check("fetch_busy", 64'(fetch_busy), 64'd0);
endtask

task automatic write_and_check(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                               input soc_pkg::strb_t strb, input soc_pkg::resp_t exp_resp);
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    do_data(1'b1, addr, data, strb, rdata, resp);
    check("data_resp", 64'(resp), 64'(exp_resp));
endtask

task automatic read_and_check(input logic use_fetch, input soc_pkg::addr_t addr,
                              input soc_pkg::data_t exp_data, input soc_pkg::resp_t exp_resp);
    soc_pkg::data_t rdata;
    soc_pkg::resp_t resp;
    if (use_fetch) begin
        do_fetch(addr, rdata, resp);
        check("fetch_rdata", rdata, exp_data);
        check("fetch_resp", 64'(resp), 64'(exp_resp));
    end else begin
        do_data(1'b0, addr, '0, '0, rdata, resp);
        check("data_rdata", rdata, exp_data);
        check("data_resp", 64'(resp), 64'(exp_resp));
    end
endtask

task automatic check_reset_state();
    check("fetch_busy", 64'(fetch_busy), 64'd0);
    check("fetch_done", 64'(fetch_done), 64'd0);
    check("data_busy", 64'(data_busy), 64'd0);
    check("data_done", 64'(data_done), 64'd0);
    check("gpio_outputs", 64'(gpio_outputs), 64'd0);
endtask

// Full-word writes so every later read sees defined data
task automatic fill_pool();
    soc_pkg::addr_t addr;
    for (int i = 0; i < 16; i++) begin
        addr = pool_base + (soc_pkg::addr_t'(i) << 3);
        model_write(addr, fill_word(addr), 8'hff);
        write_and_check(addr, fill_word(addr), 8'hff, soc_pkg::resp_okay);
    end
endtask

task automatic partial_write_merges();
    soc_pkg::addr_t addr;
    addr = pool_base + 32'h18;
    model_write(addr, 64'h1122_3344_5566_7788, 8'h3c);
    write_and_check(addr, 64'h1122_3344_5566_7788, 8'h3c, soc_pkg::resp_okay);
    read_and_check(1'b0, addr, model_read(addr), soc_pkg::resp_okay);
endtask

task automatic fetch_sees_data_writes();
    soc_pkg::addr_t addr;
    read_and_check(1'b1, pool_base + 32'h18, model_read(pool_base + 32'h18), soc_pkg::resp_okay);
    addr = pool_base + 32'h28;
    model_write(addr, 64'h0123_4567_89ab_cdef, 8'hff);
    write_and_check(addr, 64'h0123_4567_89ab_cdef, 8'hff, soc_pkg::resp_okay);
    read_and_check(1'b1, addr, model_read(addr), soc_pkg::resp_okay);
endtask

task automatic gpio_write_read();
    gpio_model_write(gpio_base, 64'hffff_ffff_ffff_ff3a, 8'h01);
    write_and_check(gpio_base, 64'hffff_ffff_ffff_ff3a, 8'h01, soc_pkg::resp_okay);
    check("gpio_outputs", 64'(gpio_outputs), 64'(gpio_model));
    // Lane 0 masked off, so the outputs hold
    gpio_model_write(gpio_base, 64'h5, 8'hfe);
    write_and_check(gpio_base, 64'h5, 8'hfe, soc_pkg::resp_okay);
    check("gpio_outputs", 64'(gpio_outputs), 64'(gpio_model));
    gpio_model_write(gpio_base + 32'h8, 64'hf, 8'hff);
    write_and_check(gpio_base + 32'h8, 64'hf, 8'hff, soc_pkg::resp_okay);
    check("gpio_outputs", 64'(gpio_outputs), 64'(gpio_model));
    read_and_check(1'b0, gpio_base, 64'(gpio_model), soc_pkg::resp_okay);
    read_and_check(1'b0, gpio_base + 32'h8, 64'd0, soc_pkg::resp_okay);
endtask

task automatic unmapped_regions();
    // These alias onto pool word 0 and the GPIO register if decoded wrongly
    write_and_check(32'h0000_0100, 64'hdead_beef_dead_beef, 8'hff, soc_pkg::resp_decerr);
    write_and_check(32'h3000_0000, 64'h0000_0000_0000_0005, 8'hff, soc_pkg::resp_decerr);
    read_and_check(1'b0, 32'h0000_0100, 64'd0, soc_pkg::resp_decerr);
    read_and_check(1'b0, 32'h3000_0000, 64'd0, soc_pkg::resp_decerr);
    read_and_check(1'b1, 32'h3000_0008, 64'd0, soc_pkg::resp_decerr);
    read_and_check(1'b1, 32'h0000_0000, 64'd0, soc_pkg::resp_decerr);
    read_and_check(1'b0, pool_base, model_read(pool_base), soc_pkg::resp_okay);
    check("gpio_outputs", 64'(gpio_outputs), 64'(gpio_model));
endtask

task automatic same_cycle_requests(input logic we, input soc_pkg::addr_t d_addr,
                                   input soc_pkg::data_t d_wdata, input soc_pkg::addr_t f_addr);
    soc_pkg::data_t exp_data;
    soc_pkg::data_t exp_fetch;
    logic seen_fetch;
    logic seen_data;
    seen_fetch = 1'b0;
    seen_data = 1'b0;
    exp_data = model_read(d_addr);
    exp_fetch = model_read(f_addr);
    if (we) begin
        model_write(d_addr, d_wdata, 8'hff);
    end
    @(negedge clk);
    while (data_busy || fetch_busy) begin
        @(negedge clk);
    end
    fetch_req = 1'b1;
    fetch_addr = f_addr;
    data_req = 1'b1;
    data_we = we;
    data_addr = d_addr;
    data_wdata = d_wdata;
    data_wstrb = 8'hff;
    @(negedge clk);
    fetch_req = 1'b0;
    data_req = 1'b0;
    while (!(seen_fetch && seen_data)) begin
        if (fetch_done) begin
            seen_fetch = 1'b1;
            check("fetch_rdata", fetch_rdata, exp_fetch);
            check("fetch_resp", 64'(fetch_resp), 64'(soc_pkg::resp_okay));
        end
        if (data_done) begin
            seen_data = 1'b1;
            // Read data only carries meaning on a load
            if (!we) begin
                check("data_rdata", data_rdata, exp_data);
            end
            check("data_resp", 64'(data_resp), 64'(soc_pkg::resp_okay));
        end
        @(negedge clk);
    end
endtask

task automatic both_ports_at_once();
    same_cycle_requests(1'b1, pool_base + 32'h38, 64'hcafe_f00d_1234_5678, pool_base + 32'h48);
    read_and_check(1'b1, pool_base + 32'h38, model_read(pool_base + 32'h38), soc_pkg::resp_okay);
    same_cycle_requests(1'b0, pool_base + 32'h50, '0, pool_base + 32'h58);
endtask

task automatic random_sram_ops();
    logic [31:0] r;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] s;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    for (int n = 0; n < 40; n++) begin
        r = $random(seed);
        lo = $random(seed);
        hi = $random(seed);
        s = $random(seed);
        addr = pool_base + soc_pkg::addr_t'({r[5:2], 3'b000});
        wdata = {hi, lo};
        // Bit 0 picks the port, only the data port writes
        if (!r[0] && r[1]) begin
            model_write(addr, wdata, s[7:0]);
            write_and_check(addr, wdata, s[7:0], soc_pkg::resp_okay);
        end else begin
            read_and_check(r[0], addr, model_read(addr), soc_pkg::resp_okay);
        end
    end
endtask

initial begin
    rst = 1'b1;
    fetch_req = 1'b0;
    fetch_addr = '0;
    data_req = 1'b0;
    data_we = 1'b0;
    data_addr = '0;
    data_wdata = '0;
    data_wstrb = '0;
    gpio_model = 4'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();

    fill_pool();
    partial_write_merges();
    fetch_sees_data_writes();
    gpio_write_read();
    unmapped_regions();
    both_ports_at_once();
    random_sram_ops();

    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

endmodule
